// File: rtl/ex_pkg.sv
// Shared types and constants for the execution unit, imported by every RTL module
`default_nettype none

package ex_pkg;

  ////////////////////////////////////////
  // Operators
  ////////////////////////////////////////

  // ALU operator, 5 bits
  typedef enum logic [4:0] {
    // Adder
    ALU_ADD,
    ALU_SUB,
    // Logic
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    // Shifts
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    // Comparisons, flag only
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_LTU,
    ALU_LE,
    ALU_LEU,
    ALU_GT,
    ALU_GTU,
    ALU_GE,
    ALU_GEU,
    // Set-less-than style
    ALU_SLT,
    ALU_SLTU,
    ALU_SLET,
    ALU_SLETU
  } alu_op_e;

  // Multiply/divide operator, all unsigned
  typedef enum logic [1:0] {
    MD_MUL,
    MD_MULHU,
    MD_DIVU,
    MD_REMU
  } md_op_e;

  // Which unit runs the request
  typedef enum logic {
    UNIT_ALU,
    UNIT_MD
  } unit_e;

  ////////////////////////////////////////
  // Request and response
  ////////////////////////////////////////

  // 72 bits in all
  typedef struct packed {
    unit_e       unit;
    alu_op_e     alu_op;
    md_op_e      md_op;
    logic [31:0] operand_a;
    logic [31:0] operand_b;
  } ex_req_t;

  // 33 bits; cmp stays low outside comparisons
  typedef struct packed {
    logic [31:0] result;
    logic        cmp;
  } ex_rsp_t;

  // One step per operand bit
  localparam int unsigned MdIterations = 32;

endpackage

`default_nettype wire

// File: rtl/ex_alu.sv
// Combinational ALU; its 33-bit adder is also lent to the multiply/divide block
`timescale 1ns/1ps
`default_nettype none

module ex_alu import ex_pkg::*; (
  input  alu_op_e     operator_i,
  input  logic [31:0] operand_a_i,
  input  logic [31:0] operand_b_i,
  // Borrowed adder operands
  input  logic [32:0] md_operand_a_i,
  input  logic [32:0] md_operand_b_i,
  input  logic        md_adder_en_i,
  output logic [33:0] adder_result_ext_o,
  output logic [31:0] result_o,
  output logic        cmp_o
);

  ////////////////////////////////////////
  // Adder
  ////////////////////////////////////////

  logic        negate_b;
  logic [32:0] operand_b_neg;
  logic [32:0] adder_in_a;
  logic [32:0] adder_in_b;
  logic [31:0] adder_result;

  // Subtract and every compare use a - b
  always_comb begin
    negate_b = 1'b0;
    unique case (operator_i)
      ALU_SUB,
      ALU_EQ,  ALU_NE,
      ALU_LT,  ALU_LTU,
      ALU_LE,  ALU_LEU,
      ALU_GT,  ALU_GTU,
      ALU_GE,  ALU_GEU,
      ALU_SLT, ALU_SLTU,
      ALU_SLET, ALU_SLETU: negate_b = 1'b1;
      default: negate_b = 1'b0;
    endcase
  end

  // Low bit is the carry in: a side always 1, b side 1 only when inverted
  assign operand_b_neg = {operand_b_i, 1'b0} ^ {33{negate_b}};
  assign adder_in_a    = md_adder_en_i ? md_operand_a_i : {operand_a_i, 1'b1};
  assign adder_in_b    = md_adder_en_i ? md_operand_b_i : operand_b_neg;

  // Bit 33 is the carry out
  assign adder_result_ext_o = {1'b0, adder_in_a} + {1'b0, adder_in_b};
  assign adder_result       = adder_result_ext_o[32:1];

  ////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////

  logic        shift_left;
  logic        shift_arith;
  logic [31:0] operand_a_rev;
  logic [31:0] shift_in;
  logic [32:0] shift_in_ext;
  logic [31:0] shift_right;
  logic [31:0] shift_right_rev;
  logic [31:0] shift_result;

  assign shift_left  = (operator_i == ALU_SLL);
  assign shift_arith = (operator_i == ALU_SRA);

  // Left shift = reversed right shift
  for (genvar i = 0; i < 32; i++) begin : gen_rev
    assign operand_a_rev[i]   = operand_a_i[31-i];
    assign shift_right_rev[i] = shift_right[31-i];
  end

  assign shift_in = shift_left ? operand_a_rev : operand_a_i;

  // Extra top bit carries the sign fill for SRA only
  assign shift_in_ext = {shift_arith & shift_in[31], shift_in};
  assign shift_right  = 32'($unsigned($signed(shift_in_ext) >>> operand_b_i[4:0]));

  assign shift_result = shift_left ? shift_right_rev : shift_right;

  ////////////////////////////////////////
  // Comparator
  ////////////////////////////////////////

  logic cmp_signed;
  logic is_equal;
  logic is_ge;
  logic cmp_result;

  always_comb begin
    unique case (operator_i)
      ALU_LT, ALU_LE, ALU_GT, ALU_GE,
      ALU_SLT, ALU_SLET: cmp_signed = 1'b1;
      default:           cmp_signed = 1'b0;
    endcase
  end

  // a - b == 0
  assign is_equal = (adder_result == 32'h0);

  // Same sign: the difference sign decides
  // Differing signs: a's sign bit decides, inverted when signed
  always_comb begin
    if (operand_a_i[31] == operand_b_i[31]) begin
      is_ge = ~adder_result[31];
    end else begin
      is_ge = operand_a_i[31] ^ cmp_signed;
    end
  end

  // Flag stays low for non-comparison operators
  always_comb begin
    unique case (operator_i)
      ALU_EQ:            cmp_result = is_equal;
      ALU_NE:            cmp_result = ~is_equal;
      ALU_GT,  ALU_GTU:  cmp_result = is_ge & ~is_equal;
      ALU_GE,  ALU_GEU:  cmp_result = is_ge;
      ALU_LT,  ALU_LTU,
      ALU_SLT, ALU_SLTU: cmp_result = ~is_ge;
      ALU_LE,  ALU_LEU,
      ALU_SLET, ALU_SLETU: cmp_result = ~is_ge | is_equal;
      default:           cmp_result = 1'b0;
    endcase
  end

  assign cmp_o = cmp_result;

  ////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////

  always_comb begin
    unique case (operator_i)
      ALU_AND:          result_o = operand_a_i & operand_b_i;
      ALU_OR:           result_o = operand_a_i | operand_b_i;
      ALU_XOR:          result_o = operand_a_i ^ operand_b_i;
      ALU_ADD, ALU_SUB: result_o = adder_result;
      ALU_SLL, ALU_SRL,
      ALU_SRA:          result_o = shift_result;
      // Any comparison returns its flag
      default:          result_o = {31'h0, cmp_result};
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/ex_multdiv.sv
// Iterative unsigned multiplier and restoring divider, stepping through the ALU adder
`timescale 1ns/1ps
`default_nettype none

module ex_multdiv import ex_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        start_i,
  input  md_op_e      md_op_i,
  input  logic [31:0] operand_a_i,
  input  logic [31:0] operand_b_i,
  // Shared adder
  input  logic [33:0] adder_result_ext_i,
  output logic        adder_en_o,
  output logic [32:0] adder_op_a_o,
  output logic [32:0] adder_op_b_o,
  output logic        done_o,
  output logic [31:0] result_o
);

  localparam int unsigned CntW = $clog2(MdIterations);

  typedef enum logic [1:0] {
    MD_IDLE,
    MD_STEP,
    MD_DONE
  } md_state_e;

  md_state_e       state_q;
  logic [CntW-1:0] cnt_q;
  logic            last_step;

  // Payload
  // acc_hi: product high word or remainder
  // acc_lo: multiplier/product low word, or dividend/quotient
  md_op_e      op_q;
  logic [31:0] acc_hi_q;
  logic [31:0] acc_lo_q;
  logic [31:0] opb_q;

  logic        is_div;
  logic [32:0] rem_shift;
  logic        div_ge;
  logic [31:0] acc_hi_d;
  logic [31:0] acc_lo_d;

  assign is_div    = (op_q == MD_DIVU) || (op_q == MD_REMU);
  assign last_step = (cnt_q == CntW'(MdIterations - 1));

  ////////////////////////////////////////
  // Step datapath
  ////////////////////////////////////////

  // Remainder shifted left by the next dividend bit
  assign rem_shift = {acc_hi_q, acc_lo_q[31]};

  // No borrow from the low 32 bits, or a set bit 32, means rem >= divisor
  assign div_ge = rem_shift[32] | adder_result_ext_i[33];

  always_comb begin
    if (is_div) begin
      // rem - divisor: invert b, both carry bits set
      adder_op_a_o = {rem_shift[31:0], 1'b1};
      adder_op_b_o = {~opb_q, 1'b1};
      acc_hi_d     = div_ge ? adder_result_ext_i[32:1] : rem_shift[31:0];
      acc_lo_d     = {acc_lo_q[30:0], div_ge};
    end else begin
      // Add multiplicand when the multiplier LSB is set, no carry in
      adder_op_a_o = {acc_hi_q, 1'b0};
      adder_op_b_o = {(acc_lo_q[0] ? opb_q : 32'h0), 1'b0};
      // 33-bit sum, shifted right one place into the low word
      acc_hi_d     = adder_result_ext_i[33:2];
      acc_lo_d     = {adder_result_ext_i[1], acc_lo_q[31:1]};
    end
  end

  assign adder_en_o = (state_q == MD_STEP);
  assign done_o     = (state_q == MD_DONE);

  ////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= MD_IDLE;
      cnt_q   <= '0;
    end else begin
      unique case (state_q)
        MD_IDLE: begin
          if (start_i) begin
            state_q <= MD_STEP;
            cnt_q   <= '0;
          end
        end
        MD_STEP: begin
          cnt_q <= cnt_q + 1'b1;
          if (last_step) begin
            state_q <= MD_DONE;
          end
        end
        // done_o is high here for one cycle
        MD_DONE: state_q <= MD_IDLE;
        default: state_q <= MD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == MD_IDLE && start_i) begin
      op_q     <= md_op_i;
      acc_hi_q <= 32'h0;
      acc_lo_q <= operand_a_i;
      opb_q    <= operand_b_i;
    end else if (state_q == MD_STEP) begin
      acc_hi_q <= acc_hi_d;
      acc_lo_q <= acc_lo_d;
    end
  end

  // Low word for MUL and DIVU, high word for MULHU and REMU
  always_comb begin
    unique case (op_q)
      MD_MUL, MD_DIVU: result_o = acc_lo_q;
      default:         result_o = acc_hi_q;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/ex_ctrl.sv
// Four-phase handshake control: captures the request, runs a unit, holds the response
`timescale 1ns/1ps
`default_nettype none

module ex_ctrl import ex_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        req_i,
  input  ex_req_t     req_data_i,
  input  logic [31:0] alu_result_i,
  input  logic        alu_cmp_i,
  input  logic        md_done_i,
  input  logic [31:0] md_result_i,
  output logic        ack_o,
  output ex_rsp_t     rsp_o,
  output alu_op_e     alu_op_o,
  output logic [31:0] operand_a_o,
  output logic [31:0] operand_b_o,
  output logic        md_start_o,
  output md_op_e      md_op_o
);

  typedef enum logic [2:0] {
    CT_IDLE,
    CT_ALU,
    CT_MD_START,
    CT_MD_WAIT,
    CT_ACK
  } ct_state_e;

  ct_state_e state_q;
  ex_req_t   req_q;
  ex_rsp_t   rsp_q;
  logic      ack_q;
  logic      req_take;

  // New request only from idle
  assign req_take = (state_q == CT_IDLE) && req_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= CT_IDLE;
      ack_q   <= 1'b0;
      rsp_q   <= '0;
    end else begin
      unique case (state_q)
        CT_IDLE: begin
          if (req_i) begin
            state_q <= (req_data_i.unit == UNIT_MD) ? CT_MD_START : CT_ALU;
          end
        end
        // ALU settles within the cycle after capture
        CT_ALU: begin
          rsp_q.result <= alu_result_i;
          rsp_q.cmp    <= alu_cmp_i;
          ack_q        <= 1'b1;
          state_q      <= CT_ACK;
        end
        CT_MD_START: state_q <= CT_MD_WAIT;
        CT_MD_WAIT: begin
          if (md_done_i) begin
            rsp_q.result <= md_result_i;
            rsp_q.cmp    <= 1'b0;
            ack_q        <= 1'b1;
            state_q      <= CT_ACK;
          end
        end
        // Hold until the requester drops req
        CT_ACK: begin
          if (!req_i) begin
            ack_q   <= 1'b0;
            state_q <= CT_IDLE;
          end
        end
        default: state_q <= CT_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_take) begin
      req_q <= req_data_i;
    end
  end

  // Held operands feed both units
  assign alu_op_o    = req_q.alu_op;
  assign md_op_o     = req_q.md_op;
  assign operand_a_o = req_q.operand_a;
  assign operand_b_o = req_q.operand_b;
  assign md_start_o  = (state_q == CT_MD_START);

  assign ack_o = ack_q;
  assign rsp_o = rsp_q;

endmodule

`default_nettype wire

// File: rtl/ex_top.sv
// Execution unit top level; connects control, ALU and multiply/divide for the requester
`timescale 1ns/1ps
`default_nettype none

module ex_top import ex_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    req_i,
  input  ex_req_t req_data_i,
  output logic    ack_o,
  output ex_rsp_t rsp_o
);

  // Control to ALU
  alu_op_e     alu_op;
  logic [31:0] operand_a;
  logic [31:0] operand_b;
  logic [31:0] alu_result;
  logic        alu_cmp;

  // Control to multiply/divide
  logic        md_start;
  md_op_e      md_op;
  logic        md_done;
  logic [31:0] md_result;

  // Borrowed adder path
  logic        md_adder_en;
  logic [32:0] md_adder_op_a;
  logic [32:0] md_adder_op_b;
  logic [33:0] adder_result_ext;

  ex_ctrl i_ex_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (req_i),
    .req_data_i   (req_data_i),
    .alu_result_i (alu_result),
    .alu_cmp_i    (alu_cmp),
    .md_done_i    (md_done),
    .md_result_i  (md_result),
    .ack_o        (ack_o),
    .rsp_o        (rsp_o),
    .alu_op_o     (alu_op),
    .operand_a_o  (operand_a),
    .operand_b_o  (operand_b),
    .md_start_o   (md_start),
    .md_op_o      (md_op)
  );

  ex_alu i_ex_alu (
    .operator_i         (alu_op),
    .operand_a_i        (operand_a),
    .operand_b_i        (operand_b),
    .md_operand_a_i     (md_adder_op_a),
    .md_operand_b_i     (md_adder_op_b),
    .md_adder_en_i      (md_adder_en),
    .adder_result_ext_o (adder_result_ext),
    .result_o           (alu_result),
    .cmp_o              (alu_cmp)
  );

  ex_multdiv i_ex_multdiv (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .start_i            (md_start),
    .md_op_i            (md_op),
    .operand_a_i        (operand_a),
    .operand_b_i        (operand_b),
    .adder_result_ext_i (adder_result_ext),
    .adder_en_o         (md_adder_en),
    .adder_op_a_o       (md_adder_op_a),
    .adder_op_b_o       (md_adder_op_b),
    .done_o             (md_done),
    .result_o           (md_result)
  );

endmodule

`default_nettype wire

// File: test/tb_ex_tasks.svh
// Testbench tasks included into the top module for operands, requests, models and compares
`ifndef TB_EX_TASKS_SVH
`define TB_EX_TASKS_SVH

////////////////////////////////////////
// Random operands
////////////////////////////////////////

// One Fibonacci step with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  logic feedback;
  feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
  return {state[30:0], feedback};
endfunction

// One LFSR step per bit taken
task automatic rand_word(output logic [31:0] value);
  for (int i = 0; i < 32; i++) begin
    lfsr_q = lfsr_next(lfsr_q);
    value  = {value[30:0], lfsr_q[0]};
  end
endtask

////////////////////////////////////////
// Failure and compares
////////////////////////////////////////

task automatic fail_run();
  $display("Simulation failed");
  $fatal(1, "Stopping on the first error at %0t ns", $time);
endtask

task automatic check_rsp(input string what, input ex_rsp_t exp, input ex_rsp_t act);
  if (act !== exp) begin
    $display("Error at %0t ns: rsp_o for %s expected result %h cmp %b, got result %h cmp %b",
             $time, what, exp.result, exp.cmp, act.result, act.cmp);
    fail_run();
  end
endtask

task automatic check_ack(input logic exp, input logic act);
  if (act !== exp) begin
    $display("Error at %0t ns: ack_o expected %b, got %b", $time, exp, act);
    fail_run();
  end
endtask

// Rising edges from req_i sampled high to ack_o seen high
task automatic check_latency(input int unsigned exp, input int unsigned act);
  if (act != exp) begin
    $display("Error at %0t ns: ack_o latency expected %0d, got %0d", $time, exp, act);
    fail_run();
  end
endtask

////////////////////////////////////////
// Reference models
////////////////////////////////////////

function automatic ex_rsp_t alu_ref(input alu_op_e op, input logic [31:0] a,
                                   input logic [31:0] b);
  ex_rsp_t rsp;
  logic    is_cmp;
  rsp    = '0;
  is_cmp = 1'b1;
  case (op)
    ALU_EQ:              rsp.cmp = (a == b);
    ALU_NE:              rsp.cmp = (a != b);
    ALU_LT,  ALU_SLT:    rsp.cmp = ($signed(a) < $signed(b));
    ALU_LTU, ALU_SLTU:   rsp.cmp = (a < b);
    ALU_LE,  ALU_SLET:   rsp.cmp = ($signed(a) <= $signed(b));
    ALU_LEU, ALU_SLETU:  rsp.cmp = (a <= b);
    ALU_GT:              rsp.cmp = ($signed(a) > $signed(b));
    ALU_GTU:             rsp.cmp = (a > b);
    ALU_GE:              rsp.cmp = ($signed(a) >= $signed(b));
    ALU_GEU:             rsp.cmp = (a >= b);
    default:             is_cmp  = 1'b0;
  endcase
  if (is_cmp) begin
    rsp.result = {31'h0, rsp.cmp};
  end else begin
    // Shifts use only the low 5 bits of b
    case (op)
      ALU_ADD: rsp.result = a + b;
      ALU_SUB: rsp.result = a - b;
      ALU_AND: rsp.result = a & b;
      ALU_OR:  rsp.result = a | b;
      ALU_XOR: rsp.result = a ^ b;
      ALU_SLL: rsp.result = a << b[4:0];
      ALU_SRL: rsp.result = a >> b[4:0];
      default: rsp.result = $signed(a) >>> b[4:0];
    endcase
  end
  return rsp;
endfunction

// Unsigned only
// Divide by zero gives all ones and the dividend
function automatic ex_rsp_t md_ref(input md_op_e op, input logic [31:0] a,
                                  input logic [31:0] b);
  ex_rsp_t     rsp;
  logic [63:0] product;
  rsp     = '0;
  product = {32'h0, a} * {32'h0, b};
  case (op)
    MD_MUL:   rsp.result = product[31:0];
    MD_MULHU: rsp.result = product[63:32];
    MD_DIVU:  rsp.result = (b == 32'h0) ? 32'hffff_ffff : a / b;
    default:  rsp.result = (b == 32'h0) ? a : a % b;
  endcase
  return rsp;
endfunction

////////////////////////////////////////
// Four-phase request
////////////////////////////////////////

task automatic do_request(input ex_req_t req, input int unsigned hold,
                          output ex_rsp_t rsp, output int unsigned latency);
  int unsigned waited;
  logic        seen;
  // Data one edge ahead of the strobe
  @(posedge clk_i);
  req_data_i <= req;
  @(posedge clk_i);
  req_i <= 1'b1;
  latency = 0;
  seen    = 1'b0;
  while (!seen && latency < MdIterations + 10) begin
    @(posedge clk_i);
    latency++;
    @(negedge clk_i);
    seen = ack_o;
  end
  if (!seen) begin
    $display("Timeout while waiting for ack_o to rise after req_i went high");
    fail_run();
  end
  rsp = rsp_o;
  // Requester keeps req_i high and nothing may move
  for (int i = 0; i < hold; i++) begin
    @(negedge clk_i);
    check_ack(1'b1, ack_o);
    check_rsp("held response", rsp, rsp_o);
  end
  @(posedge clk_i);
  req_i <= 1'b0;
  // Low req_i not sampled yet
  @(negedge clk_i);
  check_ack(1'b1, ack_o);
  waited = 0;
  while (seen && waited < 4) begin
    @(posedge clk_i);
    waited++;
    @(negedge clk_i);
    seen = ack_o;
  end
  if (seen) begin
    $display("Timeout while waiting for ack_o to fall after req_i went low");
    fail_run();
  end
endtask

`endif

// File: test/tb_ex_top.sv
// Directed testbench for the execution unit; compile with build.f and run this module as top
`timescale 1ns/1ps
`default_nettype none

module tb_ex_top import ex_pkg::*; ();

  // Edges from req_i sampled high to ack_o high
  localparam int unsigned AluLatency = 2;
  localparam int unsigned MdLatency  = MdIterations + 3;

  logic        clk_i;
  logic        rst_n_i;
  logic        req_i;
  ex_req_t     req_data_i;
  logic        ack_o;
  ex_rsp_t     rsp_o;

  logic [31:0] lfsr_q;

  ex_top i_ex_top (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (req_i),
    .req_data_i (req_data_i),
    .ack_o      (ack_o),
    .rsp_o      (rsp_o)
  );

  // 8 ns period
  always #4 clk_i = ~clk_i;

  `include "tb_ex_tasks.svh"

  ////////////////////////////////////////
  // Single requests
  ////////////////////////////////////////

  task automatic alu_request(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
                             input int unsigned hold);
    ex_req_t     req;
    ex_rsp_t     rsp;
    int unsigned latency;
    req           = '0;
    req.unit      = UNIT_ALU;
    req.alu_op    = op;
    req.operand_a = a;
    req.operand_b = b;
    do_request(req, hold, rsp, latency);
    check_rsp(op.name(), alu_ref(op, a, b), rsp);
    check_latency(AluLatency, latency);
  endtask

  task automatic md_request(input md_op_e op, input logic [31:0] a, input logic [31:0] b,
                            input int unsigned hold);
    ex_req_t     req;
    ex_rsp_t     rsp;
    int unsigned latency;
    req           = '0;
    req.unit      = UNIT_MD;
    req.md_op     = op;
    req.operand_a = a;
    req.operand_b = b;
    do_request(req, hold, rsp, latency);
    check_rsp(op.name(), md_ref(op, a, b), rsp);
    check_latency(MdLatency, latency);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic reset_idle();
    ex_rsp_t zero_rsp;
    zero_rsp = '0;
    for (int i = 0; i < 16; i++) begin
      @(negedge clk_i);
      check_ack(1'b0, ack_o);
      check_rsp("reset", zero_rsp, rsp_o);
    end
    @(posedge clk_i);
    rst_n_i <= 1'b1;
    // Still idle after release
    for (int i = 0; i < 3; i++) begin
      @(negedge clk_i);
      check_ack(1'b0, ack_o);
      check_rsp("after reset", zero_rsp, rsp_o);
    end
  endtask

  task automatic adder_logic();
    alu_op_e     ops[5]     = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR};
    logic [31:0] corners[3] = '{32'h0, 32'hffff_ffff, 32'h8000_0000};
    logic [31:0] a;
    logic [31:0] b;
    foreach (ops[i]) begin
      foreach (corners[j]) begin
        foreach (corners[k]) begin
          alu_request(ops[i], corners[j], corners[k], 0);
        end
      end
      for (int n = 0; n < 6; n++) begin
        rand_word(a);
        rand_word(b);
        alu_request(ops[i], a, b, 0);
      end
    end
  endtask

  task automatic shift_ops();
    alu_op_e     ops[3]     = '{ALU_SLL, ALU_SRL, ALU_SRA};
    logic [31:0] operands[3] = '{32'h8000_0001, 32'hffff_ffff, 32'h7654_3210};
    logic [31:0] amount;
    foreach (ops[i]) begin
      foreach (operands[j]) begin
        alu_request(ops[i], operands[j], 32'd0, 0);
        alu_request(ops[i], operands[j], 32'd31, 0);
        // Upper bits of b must be ignored
        alu_request(ops[i], operands[j], 32'hffff_ffe4, 0);
        rand_word(amount);
        alu_request(ops[i], operands[j], amount, 0);
      end
    end
  endtask

  task automatic compare_ops();
    alu_op_e     op;
    logic [31:0] a;
    logic [31:0] b;
    for (int o = int'(ALU_EQ); o <= int'(ALU_SLETU); o++) begin
      op = alu_op_e'(o);
      rand_word(a);
      alu_request(op, a, a, 0);
      // Signs differ
      alu_request(op, 32'h8000_0000, 32'h0000_0001, 0);
      alu_request(op, 32'h0000_0001, 32'h8000_0000, 0);
      alu_request(op, 32'hffff_ffff, 32'h0, 0);
      for (int n = 0; n < 4; n++) begin
        rand_word(a);
        rand_word(b);
        alu_request(op, a, b, 0);
      end
    end
  endtask

  task automatic multdiv_ops();
    md_op_e      op;
    logic [31:0] a;
    logic [31:0] b;
    for (int o = 0; o < 4; o++) begin
      op = md_op_e'(o);
      rand_word(a);
      // Divide by zero
      md_request(op, a, 32'h0, 0);
      md_request(op, 32'hffff_ffff, 32'hffff_ffff, 0);
      md_request(op, 32'h8000_0000, 32'd3, 0);
      md_request(op, 32'd7, 32'hffff_ffff, 0);
      for (int n = 0; n < 4; n++) begin
        rand_word(a);
        rand_word(b);
        md_request(op, a, b, 0);
      end
    end
  endtask

  task automatic handshake_checks();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] pick;
    // req_i held high past ack_o
    rand_word(a);
    rand_word(b);
    alu_request(ALU_SUB, a, b, 6);
    md_request(MD_MULHU, a, b, 4);
    // Back-to-back requests with units alternating
    for (int n = 0; n < 6; n++) begin
      rand_word(pick);
      rand_word(a);
      rand_word(b);
      alu_request(alu_op_e'(pick % 22), a, b, 0);
      md_request(md_op_e'(pick[1:0]), b, a, 0);
    end
  endtask

  ////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////

  initial begin
    clk_i      = 1'b0;
    rst_n_i    = 1'b0;
    req_i      = 1'b0;
    req_data_i = '0;
    lfsr_q     = 32'h7034595b;
    reset_idle();
    adder_logic();
    shift_ops();
    compare_ops();
    multdiv_ops();
    handshake_checks();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+test
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_multdiv.sv
rtl/ex_ctrl.sv
rtl/ex_top.sv
test/tb_ex_top.sv

// File: Bender.yml
package:
  name: ex_unit

sources:
  # Package first, then the blocks, then the top level
  - files:
      - rtl/ex_pkg.sv
      - rtl/ex_alu.sv
      - rtl/ex_multdiv.sv
      - rtl/ex_ctrl.sv
      - rtl/ex_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_ex_top.sv
